/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_mem_sys
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bc_msg_align.sv */
`timescale 1ns/1ns

module bc_msg_align import mem_sys_pkg::*; #(
  parameter int BC_START_ADDR = 2 ** DMEM_ADDR_WIDTH - 4 * 2 ** BC_ADDR_WIDTH
) (
  input  logic       clk,
  input  logic       rst,

  input  bc_msg_t    bc_msg_in,
  input  logic       bc_msg_in_valid,

  output logic       bc_valid,
  output dmem_addr_t bc_addr,
  output strb_t      bc_strb,
  output line_t      bc_data
);

  bc_msg_t    msg_r;
  logic       valid_r;
  dmem_addr_t word_addr;
  logic       lane;

  // Byte address of the message word inside the data memory
  assign word_addr = dmem_addr_t'({msg_r.idx, 2'b00}) + dmem_addr_t'(BC_START_ADDR);
  assign lane      = word_addr[LINE_ADDR_BITS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r  <= 1'b0;
      bc_valid <= 1'b0;
    end else begin
      valid_r  <= bc_msg_in_valid;
      bc_valid <= valid_r;
    end
  end

  // Stage one holds the raw message, stage two the line-wide write
  always_ff @(posedge clk) begin
    msg_r   <= bc_msg_in;
    bc_addr <= word_addr;
    bc_strb <= lane ? {msg_r.strb, 4'h0} : {4'h0, msg_r.strb};
    bc_data <= lane ? {msg_r.data, 32'h0} : {32'h0, msg_r.data};
  end

endmodule

/* core_port_adapter.sv */
`timescale 1ns/1ns

module core_port_adapter import mem_sys_pkg::*; (
  input  logic        clk,
  input  logic        rst,

  input  logic        core_dmem_en,
  input  logic        core_dmem_wen,
  input  logic [3:0]  core_dmem_strb,
  input  dmem_addr_t  core_dmem_addr,
  input  word_t       core_dmem_wr_data,
  output word_t       core_dmem_rd_data,
  output logic        core_dmem_rd_valid,

  bank_port_if.master bank0,
  bank_port_if.master bank1
);

  logic  bank_sel;
  logic  lane_sel;
  strb_t lane_strb;
  line_t lane_data;
  logic  bank_r;
  logic  lane_r;
  line_t rd_line;

  assign bank_sel  = core_dmem_addr[LINE_ADDR_BITS];
  assign lane_sel  = core_dmem_addr[LINE_ADDR_BITS-1];
  assign lane_strb = lane_sel ? {core_dmem_strb, 4'h0} : {4'h0, core_dmem_strb};
  assign lane_data = lane_sel ? {core_dmem_wr_data, 32'h0} : {32'h0, core_dmem_wr_data};

  // The core owns the second port of each bank, so it never waits
  assign bank0.en    = core_dmem_en && !bank_sel;
  assign bank0.rd    = !core_dmem_wen;
  assign bank0.wen   = core_dmem_wen ? lane_strb : '0;
  assign bank0.addr  = core_dmem_addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
  assign bank0.wdata = lane_data;

  assign bank1.en    = core_dmem_en && bank_sel;
  assign bank1.rd    = !core_dmem_wen;
  assign bank1.wen   = core_dmem_wen ? lane_strb : '0;
  assign bank1.addr  = core_dmem_addr[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
  assign bank1.wdata = lane_data;

  always_ff @(posedge clk) begin
    if (rst) begin
      core_dmem_rd_valid <= 1'b0;
    end else begin
      core_dmem_rd_valid <= core_dmem_en && !core_dmem_wen;
    end
  end

  // Remember where the word sits until the bank returns the line
  always_ff @(posedge clk) begin
    if (core_dmem_en) begin
      bank_r <= bank_sel;
      lane_r <= lane_sel;
    end
  end

  assign rd_line           = bank_r ? bank1.rdata : bank0.rdata;
  assign core_dmem_rd_data = lane_r ? rd_line[63:32] : rd_line[31:0];

endmodule

/* dma_rd_resp.sv */
`timescale 1ns/1ns

module dma_rd_resp import mem_sys_pkg::*; #(
  parameter int FIFO_ADDR_WIDTH = 3
) (
  input  logic  clk,
  input  logic  rst,

  input  logic  rd_grant,
  input  logic  rd_grant_bank,
  input  line_t bank0_rdata,
  input  line_t bank1_rdata,
  output logic  rd_credit,

  output logic  dma_rd_resp_valid,
  output line_t dma_rd_resp_data,
  input  logic  dma_rd_resp_ready
);

  localparam logic [FIFO_ADDR_WIDTH+1:0] DEPTH =
    (FIFO_ADDR_WIDTH+2)'(2 ** FIFO_ADDR_WIDTH);

  logic                       grant_r;
  logic                       bank_r;
  line_t                      resp_line;
  logic [FIFO_ADDR_WIDTH:0]   resp_count;
  logic [FIFO_ADDR_WIDTH+1:0] occupancy;

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_r <= 1'b0;
    end else begin
      grant_r <= rd_grant;
    end
  end

  always_ff @(posedge clk) begin
    bank_r <= rd_grant_bank;
  end

  // Bank data is valid the cycle after the grant
  assign resp_line = bank_r ? bank1_rdata : bank0_rdata;

  mem_fifo #(
    .T          (line_t),
    .ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) resp_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (grant_r),
    .in_data   (resp_line),
    .in_ready  (),
    .out_valid (dma_rd_resp_valid),
    .out_data  (dma_rd_resp_data),
    .out_ready (dma_rd_resp_ready),
    .count     (resp_count)
  );

  // Stored responses plus the one in flight must leave room for a new read
  assign occupancy = {1'b0, resp_count} + {{(FIFO_ADDR_WIDTH+1){1'b0}}, grant_r};
  assign rd_credit = occupancy < DEPTH;

endmodule

/* dma_req_queue.sv */
`timescale 1ns/1ns

module dma_req_queue import mem_sys_pkg::*; #(
  parameter int FIFO_ADDR_WIDTH = 2
) (
  input  logic       clk,
  input  logic       rst,

  input  logic       dma_cmd_wr_en,
  input  dmem_addr_t dma_cmd_wr_addr,
  input  line_t      dma_cmd_wr_data,
  input  strb_t      dma_cmd_wr_strb,
  output logic       dma_cmd_wr_ready,

  input  logic       dma_cmd_rd_en,
  input  dmem_addr_t dma_cmd_rd_addr,
  output logic       dma_cmd_rd_ready,

  dmem_req_if.queue  wr_req,
  dmem_req_if.queue  rd_req
);

  dma_wr_req_t wr_cmd;
  dma_wr_req_t wr_head;

  assign wr_cmd = '{addr: dma_cmd_wr_addr, strb: dma_cmd_wr_strb, data: dma_cmd_wr_data};

  // Shallow queues spread DMA bursts over the cycles the banks are free
  mem_fifo #(
    .T          (dma_wr_req_t),
    .ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) wr_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (dma_cmd_wr_en),
    .in_data   (wr_cmd),
    .in_ready  (dma_cmd_wr_ready),
    .out_valid (wr_req.valid),
    .out_data  (wr_head),
    .out_ready (wr_req.grant),
    .count     ()
  );

  assign wr_req.write = 1'b1;
  assign wr_req.addr  = wr_head.addr;
  assign wr_req.strb  = wr_head.strb;
  assign wr_req.data  = wr_head.data;

  mem_fifo #(
    .T          (dmem_addr_t),
    .ADDR_WIDTH (FIFO_ADDR_WIDTH)
  ) rd_fifo (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (dma_cmd_rd_en),
    .in_data   (dma_cmd_rd_addr),
    .in_ready  (dma_cmd_rd_ready),
    .out_valid (rd_req.valid),
    .out_data  (rd_req.addr),
    .out_ready (rd_req.grant),
    .count     ()
  );

  // Reads carry an address only
  assign rd_req.write = 1'b0;
  assign rd_req.strb  = '0;
  assign rd_req.data  = '0;

endmodule

/* dmem_arbiter.sv */
`timescale 1ns/1ns

module dmem_arbiter import mem_sys_pkg::*; (
  input  logic        bc_valid,
  input  dmem_addr_t  bc_addr,
  input  strb_t       bc_strb,
  input  line_t       bc_data,

  dmem_req_if.arb     wr_req,
  dmem_req_if.arb     rd_req,

  input  logic        rd_credit,
  output logic        rd_grant,
  output logic        rd_grant_bank,

  bank_port_if.master bank0,
  bank_port_if.master bank1
);

  logic       wr_ok;
  logic       rd_ok;
  logic [1:0] wr_bank_gnt;
  logic [1:0] rd_bank_gnt;
  logic [1:0] port_en;
  logic [1:0] port_rd;
  strb_t      port_wen [2];
  dmem_addr_t port_addr [2];
  line_t      port_wdata [2];

  // A read is only offered while the response path has room for it
  assign wr_ok = wr_req.valid && wr_req.write;
  assign rd_ok = rd_req.valid && !rd_req.write && rd_credit;

  //////////////////////////////////////////////////
  // Fixed priority per bank: broadcast, DMA write, DMA read
  always_comb begin
    for (int b = 0; b < 2; b++) begin
      port_en[b]     = 1'b0;
      port_rd[b]     = 1'b0;
      wr_bank_gnt[b] = 1'b0;
      rd_bank_gnt[b] = 1'b0;
      port_wen[b]    = '0;
      port_addr[b]   = wr_req.addr;
      port_wdata[b]  = wr_req.data;

      if (bc_valid && bc_addr[LINE_ADDR_BITS] == 1'(b)) begin
        port_en[b]    = 1'b1;
        port_wen[b]   = bc_strb;
        port_addr[b]  = bc_addr;
        port_wdata[b] = bc_data;
      end else if (wr_ok && wr_req.addr[LINE_ADDR_BITS] == 1'(b)) begin
        port_en[b]     = 1'b1;
        port_wen[b]    = wr_req.strb;
        wr_bank_gnt[b] = 1'b1;
      end else if (rd_ok && rd_req.addr[LINE_ADDR_BITS] == 1'(b)) begin
        port_en[b]     = 1'b1;
        port_rd[b]     = 1'b1;
        port_addr[b]   = rd_req.addr;
        rd_bank_gnt[b] = 1'b1;
      end
    end
  end

  assign wr_req.grant  = |wr_bank_gnt;
  assign rd_req.grant  = |rd_bank_gnt;
  assign rd_grant      = |rd_bank_gnt;
  assign rd_grant_bank = rd_bank_gnt[1];

  //////////////////////////////////////////////////
  // Bank ports take the line index above the bank bit
  assign bank0.en    = port_en[0];
  assign bank0.rd    = port_rd[0];
  assign bank0.wen   = port_wen[0];
  assign bank0.addr  = port_addr[0][DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
  assign bank0.wdata = port_wdata[0];

  assign bank1.en    = port_en[1];
  assign bank1.rd    = port_rd[1];
  assign bank1.wen   = port_wen[1];
  assign bank1.addr  = port_addr[1][DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS+1];
  assign bank1.wdata = port_wdata[1];

endmodule

/* dmem_bank.sv */
`timescale 1ns/1ns

module dmem_bank import mem_sys_pkg::*; (
  input  logic     clk,
  bank_port_if.ram port_a,
  bank_port_if.ram port_b
);

  line_t mem [2 ** BANK_ADDR_WIDTH];

  // Both ports write per byte and return the old line on a read
  always_ff @(posedge clk) begin
    if (port_a.en) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        if (port_a.wen[i]) begin
          mem[port_a.addr][8*i +: 8] <= port_a.wdata[8*i +: 8];
        end
      end
      if (port_a.rd) begin
        port_a.rdata <= mem[port_a.addr];
      end
    end

    if (port_b.en) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        if (port_b.wen[i]) begin
          mem[port_b.addr][8*i +: 8] <= port_b.wdata[8*i +: 8];
        end
      end
      if (port_b.rd) begin
        port_b.rdata <= mem[port_b.addr];
      end
    end
  end

endmodule

/* mem_fifo.sv */
`timescale 1ns/1ns

module mem_fifo #(
  parameter type T          = logic [7:0],
  parameter int  ADDR_WIDTH = 2
) (
  input  logic                clk,
  input  logic                rst,

  input  logic                in_valid,
  input  T                    in_data,
  output logic                in_ready,

  output logic                out_valid,
  output T                    out_data,
  input  logic                out_ready,

  output logic [ADDR_WIDTH:0] count
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  T                      mem [DEPTH];
  logic [ADDR_WIDTH-1:0] wr_ptr;
  logic [ADDR_WIDTH-1:0] rd_ptr;
  logic                  push;
  logic                  pop;

  // The top count bit is set only when every entry is taken
  assign in_ready  = !count[ADDR_WIDTH];
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Pointers wrap on their own since the depth is a power of two
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* mem_sys_if.sv */
`timescale 1ns/1ns

// A queued DMA request waiting at the bank arbiter
interface dmem_req_if import mem_sys_pkg::*; ();
  logic       valid;
  logic       write;
  dmem_addr_t addr;
  strb_t      strb;
  line_t      data;
  logic       grant;

  modport queue (output valid, write, addr, strb, data, input grant);
  modport arb (input valid, write, addr, strb, data, output grant);
endinterface

// One port of a memory bank, addressed by line index inside the bank
interface bank_port_if import mem_sys_pkg::*; ();
  logic                       en;
  logic                       rd;
  strb_t                      wen;
  logic [BANK_ADDR_WIDTH-1:0] addr;
  line_t                      wdata;
  line_t                      rdata;

  modport master (output en, rd, wen, addr, wdata, input rdata);
  modport ram (input en, rd, wen, addr, wdata, output rdata);
endinterface

/* mem_sys_pkg.sv */
package mem_sys_pkg;

  // Line geometry of the data memory
  localparam int LINE_BYTES      = 8;
  localparam int LINE_ADDR_BITS  = 3;
  localparam int DMEM_ADDR_WIDTH = 15;

  // Lines are interleaved over two banks by the bit above the line offset
  localparam int BANK_ADDR_WIDTH = DMEM_ADDR_WIDTH - LINE_ADDR_BITS - 1;

  // Word index inside the 4 KiB broadcast region at the top of memory
  localparam int BC_ADDR_WIDTH   = 10;

  typedef logic [8*LINE_BYTES-1:0]    line_t;
  typedef logic [LINE_BYTES-1:0]      strb_t;
  typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
  typedef logic [31:0]                word_t;

  typedef struct packed {
    logic [BC_ADDR_WIDTH-1:0] idx;
    logic [3:0]               strb;
    word_t                    data;
  } bc_msg_t;

  typedef struct packed {
    dmem_addr_t addr;
    strb_t      strb;
    line_t      data;
  } dma_wr_req_t;

endpackage

/* mem_sys_top.sv */
`timescale 1ns/1ns

module mem_sys_top import mem_sys_pkg::*; #(
  parameter int REQ_FIFO_ADDR_WIDTH  = 2,
  parameter int RESP_FIFO_ADDR_WIDTH = 3,
  parameter int BC_START_ADDR        = 2 ** DMEM_ADDR_WIDTH - 4 * 2 ** BC_ADDR_WIDTH
) (
  input  logic       clk,
  input  logic       rst,

  input  logic       dma_cmd_wr_en,
  input  dmem_addr_t dma_cmd_wr_addr,
  input  line_t      dma_cmd_wr_data,
  input  strb_t      dma_cmd_wr_strb,
  output logic       dma_cmd_wr_ready,

  input  logic       dma_cmd_rd_en,
  input  dmem_addr_t dma_cmd_rd_addr,
  output logic       dma_cmd_rd_ready,

  output logic       dma_rd_resp_valid,
  output line_t      dma_rd_resp_data,
  input  logic       dma_rd_resp_ready,

  input  logic       core_dmem_en,
  input  logic       core_dmem_wen,
  input  logic [3:0] core_dmem_strb,
  input  dmem_addr_t core_dmem_addr,
  input  word_t      core_dmem_wr_data,
  output word_t      core_dmem_rd_data,
  output logic       core_dmem_rd_valid,

  input  bc_msg_t    bc_msg_in,
  input  logic       bc_msg_in_valid
);

  logic       bc_valid;
  dmem_addr_t bc_addr;
  strb_t      bc_strb;
  line_t      bc_data;
  logic       rd_credit;
  logic       rd_grant;
  logic       rd_grant_bank;

  dmem_req_if  wr_req ();
  dmem_req_if  rd_req ();
  bank_port_if arb_b0 ();
  bank_port_if arb_b1 ();
  bank_port_if core_b0 ();
  bank_port_if core_b1 ();

  //////////////////////////////////////////////////
  // Request side
  dma_req_queue #(
    .FIFO_ADDR_WIDTH (REQ_FIFO_ADDR_WIDTH)
  ) dma_req_queue_i (
    .clk              (clk),
    .rst              (rst),
    .dma_cmd_wr_en    (dma_cmd_wr_en),
    .dma_cmd_wr_addr  (dma_cmd_wr_addr),
    .dma_cmd_wr_data  (dma_cmd_wr_data),
    .dma_cmd_wr_strb  (dma_cmd_wr_strb),
    .dma_cmd_wr_ready (dma_cmd_wr_ready),
    .dma_cmd_rd_en    (dma_cmd_rd_en),
    .dma_cmd_rd_addr  (dma_cmd_rd_addr),
    .dma_cmd_rd_ready (dma_cmd_rd_ready),
    .wr_req           (wr_req),
    .rd_req           (rd_req)
  );

  bc_msg_align #(
    .BC_START_ADDR (BC_START_ADDR)
  ) bc_msg_align_i (
    .clk             (clk),
    .rst             (rst),
    .bc_msg_in       (bc_msg_in),
    .bc_msg_in_valid (bc_msg_in_valid),
    .bc_valid        (bc_valid),
    .bc_addr         (bc_addr),
    .bc_strb         (bc_strb),
    .bc_data         (bc_data)
  );

  //////////////////////////////////////////////////
  // Banks and the shared port arbiter
  dmem_arbiter dmem_arbiter_i (
    .bc_valid      (bc_valid),
    .bc_addr       (bc_addr),
    .bc_strb       (bc_strb),
    .bc_data       (bc_data),
    .wr_req        (wr_req),
    .rd_req        (rd_req),
    .rd_credit     (rd_credit),
    .rd_grant      (rd_grant),
    .rd_grant_bank (rd_grant_bank),
    .bank0         (arb_b0),
    .bank1         (arb_b1)
  );

  dmem_bank dmem_bank0_i (
    .clk    (clk),
    .port_a (arb_b0),
    .port_b (core_b0)
  );

  dmem_bank dmem_bank1_i (
    .clk    (clk),
    .port_a (arb_b1),
    .port_b (core_b1)
  );

  //////////////////////////////////////////////////
  // Response side
  core_port_adapter core_port_adapter_i (
    .clk                (clk),
    .rst                (rst),
    .core_dmem_en       (core_dmem_en),
    .core_dmem_wen      (core_dmem_wen),
    .core_dmem_strb     (core_dmem_strb),
    .core_dmem_addr     (core_dmem_addr),
    .core_dmem_wr_data  (core_dmem_wr_data),
    .core_dmem_rd_data  (core_dmem_rd_data),
    .core_dmem_rd_valid (core_dmem_rd_valid),
    .bank0              (core_b0),
    .bank1              (core_b1)
  );

  dma_rd_resp #(
    .FIFO_ADDR_WIDTH (RESP_FIFO_ADDR_WIDTH)
  ) dma_rd_resp_i (
    .clk               (clk),
    .rst               (rst),
    .rd_grant          (rd_grant),
    .rd_grant_bank     (rd_grant_bank),
    .bank0_rdata       (arb_b0.rdata),
    .bank1_rdata       (arb_b1.rdata),
    .rd_credit         (rd_credit),
    .dma_rd_resp_valid (dma_rd_resp_valid),
    .dma_rd_resp_data  (dma_rd_resp_data),
    .dma_rd_resp_ready (dma_rd_resp_ready)
  );

endmodule

/* project.f */
mem_sys_pkg.sv
mem_sys_if.sv
mem_fifo.sv
dma_req_queue.sv
bc_msg_align.sv
dmem_arbiter.sv
dmem_bank.sv
core_port_adapter.sv
dma_rd_resp.sv
mem_sys_top.sv
tb_mem_sys.sv

/* tb_mem_sys.sv */
`timescale 1ns/1ns

module tb_mem_sys import mem_sys_pkg::*; ();

  localparam logic [31:0] SEED = 32'hd9f4_ef66;
  localparam int REQ_AW    = 2;
  localparam int RESP_AW   = 3;
  localparam int BC_START  = 2 ** DMEM_ADDR_WIDTH - 4 * 2 ** BC_ADDR_WIDTH;
  localparam int N_LINES   = 16;
  localparam int N_CORE    = 8;
  localparam int N_BC      = 12;
  localparam int N_BURST   = 64;
  localparam int BC_LINES  = BC_START / LINE_BYTES;

  // Request queue depth plus the broadcast pipeline covers any pending write
  localparam int DRAIN_CYCLES   = 2 ** REQ_AW + 4;
  localparam int TOTAL_OPS      = 5 * N_LINES + 2 * N_CORE + 5 * N_BC + N_BURST;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_OPS + 1000;

  logic       clk = 1'b0;
  logic       rst;
  logic       dma_cmd_wr_en;
  dmem_addr_t dma_cmd_wr_addr;
  line_t      dma_cmd_wr_data;
  strb_t      dma_cmd_wr_strb;
  logic       dma_cmd_wr_ready;
  logic       dma_cmd_rd_en;
  dmem_addr_t dma_cmd_rd_addr;
  logic       dma_cmd_rd_ready;
  logic       dma_rd_resp_valid;
  line_t      dma_rd_resp_data;
  logic       dma_rd_resp_ready = 1'b1;
  logic       core_dmem_en;
  logic       core_dmem_wen;
  logic [3:0] core_dmem_strb;
  dmem_addr_t core_dmem_addr;
  word_t      core_dmem_wr_data;
  word_t      core_dmem_rd_data;
  logic       core_dmem_rd_valid;
  bc_msg_t    bc_msg_in;
  logic       bc_msg_in_valid;

  // Byte-wide model of the whole data memory
  logic [7:0] model_mem [2 ** DMEM_ADDR_WIDTH];
  line_t      exp_q [$];
  line_t      exp_line;

  dmem_addr_t               line_addr [N_LINES];
  dmem_addr_t               burst_addr [N_BURST];
  logic [BC_ADDR_WIDTH-1:0] bc_idx [N_BC];
  logic [3:0]               bc_s [N_BC];
  word_t                    bc_d [N_BC];
  dmem_addr_t               bc_wr_addr [N_BC];
  strb_t                    bc_wr_strb [N_BC];
  line_t                    bc_wr_data [N_BC];
  logic                     bp_pattern [256];
  logic [7:0]               bp_idx = '0;
  logic                     bp_enable = 1'b0;

  int dma_errs    = 0;
  int core_errs   = 0;
  int other_errs  = 0;
  int rd_issued   = 0;
  int resp_seen   = 0;
  int cycle_count = 0;

  always #4 clk = ~clk;

  mem_sys_top #(
    .REQ_FIFO_ADDR_WIDTH  (REQ_AW),
    .RESP_FIFO_ADDR_WIDTH (RESP_AW),
    .BC_START_ADDR        (BC_START)
  ) mem_sys_top_i (
    .clk                (clk),
    .rst                (rst),
    .dma_cmd_wr_en      (dma_cmd_wr_en),
    .dma_cmd_wr_addr    (dma_cmd_wr_addr),
    .dma_cmd_wr_data    (dma_cmd_wr_data),
    .dma_cmd_wr_strb    (dma_cmd_wr_strb),
    .dma_cmd_wr_ready   (dma_cmd_wr_ready),
    .dma_cmd_rd_en      (dma_cmd_rd_en),
    .dma_cmd_rd_addr    (dma_cmd_rd_addr),
    .dma_cmd_rd_ready   (dma_cmd_rd_ready),
    .dma_rd_resp_valid  (dma_rd_resp_valid),
    .dma_rd_resp_data   (dma_rd_resp_data),
    .dma_rd_resp_ready  (dma_rd_resp_ready),
    .core_dmem_en       (core_dmem_en),
    .core_dmem_wen      (core_dmem_wen),
    .core_dmem_strb     (core_dmem_strb),
    .core_dmem_addr     (core_dmem_addr),
    .core_dmem_wr_data  (core_dmem_wr_data),
    .core_dmem_rd_data  (core_dmem_rd_data),
    .core_dmem_rd_valid (core_dmem_rd_valid),
    .bc_msg_in          (bc_msg_in),
    .bc_msg_in_valid    (bc_msg_in_valid)
  );

  //////////////////////////////////////////////////
  // Reference model

  function automatic line_t ref_line(input dmem_addr_t a);
    line_t      l;
    dmem_addr_t base;
    base = {a[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS], {LINE_ADDR_BITS{1'b0}}};
    for (int i = 0; i < LINE_BYTES; i++) begin
      l[8*i +: 8] = model_mem[base + dmem_addr_t'(i)];
    end
    return l;
  endfunction

  function automatic word_t ref_word(input dmem_addr_t a);
    word_t      w;
    dmem_addr_t base;
    base = {a[DMEM_ADDR_WIDTH-1:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = model_mem[base + dmem_addr_t'(i)];
    end
    return w;
  endfunction

  // Broadcast word k lands at the region start plus four bytes per word
  function automatic dmem_addr_t bc_word_addr(input logic [BC_ADDR_WIDTH-1:0] k);
    return dmem_addr_t'(BC_START) + dmem_addr_t'({k, 2'b00});
  endfunction

  task automatic model_write_line(input dmem_addr_t a, input strb_t s, input line_t d);
    dmem_addr_t base;
    base = {a[DMEM_ADDR_WIDTH-1:LINE_ADDR_BITS], {LINE_ADDR_BITS{1'b0}}};
    for (int i = 0; i < LINE_BYTES; i++) begin
      if (s[i]) begin
        model_mem[base + dmem_addr_t'(i)] = d[8*i +: 8];
      end
    end
  endtask

  task automatic model_write_word(input dmem_addr_t a, input logic [3:0] s, input word_t d);
    dmem_addr_t base;
    base = {a[DMEM_ADDR_WIDTH-1:2], 2'b00};
    for (int i = 0; i < 4; i++) begin
      if (s[i]) begin
        model_mem[base + dmem_addr_t'(i)] = d[8*i +: 8];
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Drivers, each entered and left on a falling edge

  task automatic dma_write(input dmem_addr_t a, input strb_t s, input line_t d);
    logic accepted;
    dma_cmd_wr_en   = 1'b1;
    dma_cmd_wr_addr = a;
    dma_cmd_wr_strb = s;
    dma_cmd_wr_data = d;
    accepted        = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = dma_cmd_wr_ready;
      @(negedge clk);
    end
    dma_cmd_wr_en = 1'b0;
    model_write_line(a, s, d);
  endtask

  task automatic dma_read(input dmem_addr_t a);
    logic accepted;
    dma_cmd_rd_en   = 1'b1;
    dma_cmd_rd_addr = a;
    accepted        = 1'b0;
    while (!accepted) begin
      @(posedge clk);
      accepted = dma_cmd_rd_ready;
      @(negedge clk);
    end
    dma_cmd_rd_en = 1'b0;
    exp_q.push_back(ref_line(a));
    rd_issued++;
  endtask

  task automatic core_write(input dmem_addr_t a, input logic [3:0] s, input word_t d);
    core_dmem_en      = 1'b1;
    core_dmem_wen     = 1'b1;
    core_dmem_addr    = a;
    core_dmem_strb    = s;
    core_dmem_wr_data = d;
    @(negedge clk);
    core_dmem_en  = 1'b0;
    core_dmem_wen = 1'b0;
    model_write_word(a, s, d);
  endtask

  // The read word must show up exactly one cycle after the request
  task automatic core_read_check(input dmem_addr_t a);
    word_t exp;
    exp            = ref_word(a);
    core_dmem_en   = 1'b1;
    core_dmem_wen  = 1'b0;
    core_dmem_addr = a;
    @(negedge clk);
    core_dmem_en = 1'b0;
    assert (core_dmem_rd_valid === 1'b1) else begin
      $display("Error: core_dmem_rd_valid got %h expected 1 (addr %h)", core_dmem_rd_valid, a);
      core_errs++;
    end
    assert (core_dmem_rd_data === exp) else begin
      $display("Error: core_dmem_rd_data got %h expected %h (addr %h)",
               core_dmem_rd_data, exp, a);
      core_errs++;
    end
    @(negedge clk);
    assert (core_dmem_rd_valid === 1'b0) else begin
      $display("Error: core_dmem_rd_valid got %h expected 0 after one cycle", core_dmem_rd_valid);
      core_errs++;
    end
  endtask

  task automatic settle();
    repeat (DRAIN_CYCLES) @(negedge clk);
  endtask

  task automatic wait_responses();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////
  // Response checking and run limit

  always @(posedge clk) begin
    if (!rst && dma_rd_resp_valid && dma_rd_resp_ready) begin
      resp_seen++;
      assert (exp_q.size() > 0) else begin
        $display("DMA read response arrived with no read outstanding");
        dma_errs++;
      end
      if (exp_q.size() > 0) begin
        exp_line = exp_q.pop_front();
        assert (dma_rd_resp_data === exp_line) else begin
          $display("Error: dma_rd_resp_data got %h expected %h (response %0d)",
                   dma_rd_resp_data, exp_line, resp_seen);
          dma_errs++;
        end
      end
    end
  end

  // Random stalls of the response consumer
  always @(negedge clk) begin
    if (bp_enable) begin
      dma_rd_resp_ready <= bp_pattern[bp_idx];
      bp_idx            <= bp_idx + 1'b1;
    end else begin
      dma_rd_resp_ready <= 1'b1;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles with %0d DMA reads still unanswered",
               cycle_count, exp_q.size());
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence

  initial begin
    dmem_addr_t wa;
    dmem_addr_t la;
    int         sel;

    void'($urandom(SEED));
    rst               = 1'b1;
    dma_cmd_wr_en     = 1'b0;
    dma_cmd_wr_addr   = '0;
    dma_cmd_wr_data   = '0;
    dma_cmd_wr_strb   = '0;
    dma_cmd_rd_en     = 1'b0;
    dma_cmd_rd_addr   = '0;
    core_dmem_en      = 1'b0;
    core_dmem_wen     = 1'b0;
    core_dmem_strb    = '0;
    core_dmem_addr    = '0;
    core_dmem_wr_data = '0;
    bc_msg_in         = '0;
    bc_msg_in_valid   = 1'b0;

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // Idle state right after reset
    assert (dma_rd_resp_valid === 1'b0) else begin
      $display("Error: dma_rd_resp_valid got %h expected 0 after reset", dma_rd_resp_valid);
      other_errs++;
    end
    assert (core_dmem_rd_valid === 1'b0) else begin
      $display("Error: core_dmem_rd_valid got %h expected 0 after reset", core_dmem_rd_valid);
      other_errs++;
    end
    assert (dma_cmd_wr_ready === 1'b1) else begin
      $display("Error: dma_cmd_wr_ready got %h expected 1 after reset", dma_cmd_wr_ready);
      other_errs++;
    end
    assert (dma_cmd_rd_ready === 1'b1) else begin
      $display("Error: dma_cmd_rd_ready got %h expected 1 after reset", dma_cmd_rd_ready);
      other_errs++;
    end

    // Full line writes first so that no byte read later is undefined
    for (int i = 0; i < N_LINES; i++) begin
      line_addr[i]    = dmem_addr_t'(($urandom % BC_LINES) * LINE_BYTES);
      line_addr[i][3] = i[0];
      dma_write(line_addr[i], 8'hff, line_t'({$urandom, $urandom}));
    end
    for (int i = 0; i < N_LINES; i++) begin
      dma_write(line_addr[i], strb_t'($urandom), line_t'({$urandom, $urandom}));
    end
    settle();
    for (int i = 0; i < N_LINES; i++) begin
      dma_read(line_addr[i]);
    end
    wait_responses();

    // Core word writes with read-back, then both lanes of every DMA line
    for (int j = 0; j < N_CORE; j++) begin
      wa    = line_addr[j];
      wa[2] = 1'($urandom);
      core_write(wa, 4'($urandom), word_t'($urandom));
      core_read_check(wa);
    end
    for (int i = 0; i < N_LINES; i++) begin
      core_read_check(line_addr[i]);
      core_read_check(line_addr[i] + dmem_addr_t'(4));
    end

    // Broadcast words, with DMA writes racing for the same bank
    for (int m = 0; m < N_BC; m++) begin
      bc_idx[m]     = BC_ADDR_WIDTH'($urandom);
      bc_s[m]       = 4'($urandom);
      bc_d[m]       = word_t'($urandom);
      wa            = bc_word_addr(bc_idx[m]);
      sel           = 2 * int'($urandom % (N_LINES / 2)) + int'(wa[LINE_ADDR_BITS]);
      bc_wr_addr[m] = line_addr[sel];
      bc_wr_strb[m] = strb_t'($urandom);
      bc_wr_data[m] = line_t'({$urandom, $urandom});
      dma_write(wa, 8'hff, line_t'({$urandom, $urandom}));
    end
    settle();
    fork
      begin
        for (int m = 0; m < N_BC; m++) begin
          bc_msg_in       = '{idx: bc_idx[m], strb: bc_s[m], data: bc_d[m]};
          bc_msg_in_valid = 1'b1;
          model_write_word(bc_word_addr(bc_idx[m]), bc_s[m], bc_d[m]);
          @(negedge clk);
        end
        bc_msg_in_valid = 1'b0;
      end
      begin
        // One cycle later both requests meet at the arbiter together
        @(negedge clk);
        for (int m = 0; m < N_BC; m++) begin
          dma_write(bc_wr_addr[m], bc_wr_strb[m], bc_wr_data[m]);
        end
      end
    join
    settle();
    for (int m = 0; m < N_BC; m++) begin
      la = bc_word_addr(bc_idx[m]);
      dma_read(la);
      dma_read(bc_wr_addr[m]);
    end
    wait_responses();

    // Long read burst against a stalling consumer
    for (int n = 0; n < N_BURST; n++) begin
      burst_addr[n] = line_addr[$urandom % N_LINES];
    end
    for (int n = 0; n < 256; n++) begin
      bp_pattern[n] = 1'($urandom);
    end
    bp_enable = 1'b1;
    for (int n = 0; n < N_BURST; n++) begin
      dma_read(burst_addr[n]);
    end
    wait_responses();
    bp_enable = 1'b0;

    // Any extra response still held in the response FIFO drains here
    settle();

    assert (resp_seen == rd_issued) else begin
      $display("DMA issued %0d reads but %0d responses came back", rd_issued, resp_seen);
      other_errs++;
    end

    $display("Errors: dma %0d, core %0d, other %0d", dma_errs, core_errs, other_errs);
    if (dma_errs + core_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
